// ==== controlPkg.sv ====
package controlPkg;

    // One instruction word seen as R-type or I-type fields
    typedef union packed {
        struct packed {
            logic [5:0] opCode;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } rType;
        struct packed {
            logic [5:0]  opCode;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm;
        } iType;
    } instrWord;

    // Primary opcodes
    localparam logic [5:0] opTypeR  = 6'b000000;
    localparam logic [5:0] opTypeBi = 6'b000001;
    localparam logic [5:0] opJ      = 6'b000010;
    localparam logic [5:0] opJal    = 6'b000011;
    localparam logic [5:0] opBeq    = 6'b000100;
    localparam logic [5:0] opBne    = 6'b000101;
    localparam logic [5:0] opBlez   = 6'b000110;
    localparam logic [5:0] opBgtz   = 6'b000111;
    localparam logic [5:0] opAddi   = 6'b001000;
    localparam logic [5:0] opAddiu  = 6'b001001;
    localparam logic [5:0] opSlti   = 6'b001010;
    localparam logic [5:0] opSltiu  = 6'b001011;
    localparam logic [5:0] opAndi   = 6'b001100;
    localparam logic [5:0] opOri    = 6'b001101;
    localparam logic [5:0] opXori   = 6'b001110;
    localparam logic [5:0] opLui    = 6'b001111;
    localparam logic [5:0] opLb     = 6'b100000;
    localparam logic [5:0] opLh     = 6'b100001;
    localparam logic [5:0] opLw     = 6'b100011;
    localparam logic [5:0] opLbu    = 6'b100100;
    localparam logic [5:0] opLhu    = 6'b100101;
    localparam logic [5:0] opSb     = 6'b101000;
    localparam logic [5:0] opSh     = 6'b101001;
    localparam logic [5:0] opSw     = 6'b101011;

    // R-type function codes
    localparam logic [5:0] functSll     = 6'b000000;
    localparam logic [5:0] functSrl     = 6'b000010;
    localparam logic [5:0] functSra     = 6'b000011;
    localparam logic [5:0] functSllv    = 6'b000100;
    localparam logic [5:0] functSrlv    = 6'b000110;
    localparam logic [5:0] functSrav    = 6'b000111;
    localparam logic [5:0] functJr      = 6'b001000;
    localparam logic [5:0] functJalr    = 6'b001001;
    localparam logic [5:0] functMovz    = 6'b001010;
    localparam logic [5:0] functMovn    = 6'b001011;
    localparam logic [5:0] functSyscall = 6'b001100;
    localparam logic [5:0] functBreak   = 6'b001101;
    localparam logic [5:0] functAdd     = 6'b100000;
    localparam logic [5:0] functAddu    = 6'b100001;
    localparam logic [5:0] functSub     = 6'b100010;
    localparam logic [5:0] functSubu    = 6'b100011;
    localparam logic [5:0] functAnd     = 6'b100100;
    localparam logic [5:0] functOr      = 6'b100101;
    localparam logic [5:0] functXor     = 6'b100110;
    localparam logic [5:0] functNor     = 6'b100111;
    localparam logic [5:0] functSlt     = 6'b101010;
    localparam logic [5:0] functSltu    = 6'b101011;

    // Regimm branch codes in the rt field
    localparam logic [4:0] rtBltz   = 5'b00000;
    localparam logic [4:0] rtBgez   = 5'b00001;
    localparam logic [4:0] rtBltzal = 5'b10000;
    localparam logic [4:0] rtBgezal = 5'b10001;

    // Datapath control word bit positions
    // Bits 9 and 7 are spare and stay low
    localparam int dpWidth         = 15;
    localparam int dpJump          = 14;
    localparam int dpBranchOrJr    = 13;
    localparam int dpLink          = 12;
    localparam int dpAluSrcImm     = 11;
    localparam int dpMovc          = 10;
    localparam int dpRegDst        = 8;
    localparam int dpMemRead       = 6;
    localparam int dpMemWrite      = 5;
    localparam int dpMemHalf       = 4;
    localparam int dpMemByte       = 3;
    localparam int dpMemSignExtend = 2;
    localparam int dpRegWrite      = 1;
    localparam int dpMemToReg      = 0;

    // ALU operation codes
    localparam int aluOpWidth = 5;
    localparam logic [4:0] aluAdd  = 5'd0;
    localparam logic [4:0] aluAddu = 5'd1;
    localparam logic [4:0] aluSub  = 5'd2;
    localparam logic [4:0] aluSubu = 5'd3;
    localparam logic [4:0] aluAnd  = 5'd4;
    localparam logic [4:0] aluOr   = 5'd5;
    localparam logic [4:0] aluXor  = 5'd6;
    localparam logic [4:0] aluNor  = 5'd7;
    localparam logic [4:0] aluSlt  = 5'd8;
    localparam logic [4:0] aluSltu = 5'd9;
    localparam logic [4:0] aluSll  = 5'd10;
    localparam logic [4:0] aluSrl  = 5'd11;
    localparam logic [4:0] aluSra  = 5'd12;
    localparam logic [4:0] aluSllv = 5'd13;
    localparam logic [4:0] aluSrlv = 5'd14;
    localparam logic [4:0] aluSrav = 5'd15;
    localparam logic [4:0] aluSllc = 5'd16;

    // Next-PC select
    localparam logic [1:0] pcSeq     = 2'b00;
    localparam logic [1:0] pcJumpReg = 2'b01;
    localparam logic [1:0] pcBranch  = 2'b10;
    localparam logic [1:0] pcJumpImm = 2'b11;

endpackage

// ==== mainDecoder.sv ====
`timescale 1ns/1ps

module mainDecoder (
    input  controlPkg::instrWord          instr,
    input  logic                          stall,
    output logic [controlPkg::dpWidth-1:0] dpWord,
    output logic                          signExtend,
    output logic                          excSys,
    output logic                          excBp
);

    logic [5:0] opCode;
    logic [5:0] funct;
    logic [4:0] rtCode;

    assign opCode = instr.rType.opCode;
    assign funct  = instr.rType.funct;
    assign rtCode = instr.iType.rt;

    always_comb begin
        dpWord = '0;
        if (!stall) begin
            case (opCode)
                controlPkg::opTypeR: begin
                    case (funct)
                        controlPkg::functAdd, controlPkg::functAddu, controlPkg::functSub,
                        controlPkg::functSubu, controlPkg::functAnd, controlPkg::functOr,
                        controlPkg::functXor, controlPkg::functNor, controlPkg::functSlt,
                        controlPkg::functSltu, controlPkg::functSll, controlPkg::functSrl,
                        controlPkg::functSra, controlPkg::functSllv, controlPkg::functSrlv,
                        controlPkg::functSrav: begin
                            dpWord[controlPkg::dpRegWrite] = 1'b1;
                            dpWord[controlPkg::dpRegDst]   = 1'b1;
                        end
                        controlPkg::functMovn, controlPkg::functMovz: begin
                            dpWord[controlPkg::dpRegWrite] = 1'b1;
                            dpWord[controlPkg::dpRegDst]   = 1'b1;
                            dpWord[controlPkg::dpMovc]     = 1'b1;
                        end
                        controlPkg::functJr: begin
                            dpWord[controlPkg::dpJump]       = 1'b1;
                            dpWord[controlPkg::dpBranchOrJr] = 1'b1;
                        end
                        controlPkg::functJalr: begin
                            dpWord[controlPkg::dpJump]       = 1'b1;
                            dpWord[controlPkg::dpBranchOrJr] = 1'b1;
                            dpWord[controlPkg::dpLink]       = 1'b1;
                            dpWord[controlPkg::dpRegWrite]   = 1'b1;
                            dpWord[controlPkg::dpRegDst]     = 1'b1;
                        end
                        // Syscall, break and unknown functs leave the word clear
                        default: dpWord = '0;
                    endcase
                end
                controlPkg::opTypeBi: begin
                    case (rtCode)
                        controlPkg::rtBltz, controlPkg::rtBgez: begin
                            dpWord[controlPkg::dpBranchOrJr] = 1'b1;
                        end
                        controlPkg::rtBltzal, controlPkg::rtBgezal: begin
                            dpWord[controlPkg::dpBranchOrJr] = 1'b1;
                            dpWord[controlPkg::dpLink]       = 1'b1;
                            dpWord[controlPkg::dpRegWrite]   = 1'b1;
                        end
                        default: dpWord = '0;
                    endcase
                end
                controlPkg::opJ: dpWord[controlPkg::dpJump] = 1'b1;
                controlPkg::opJal: begin
                    dpWord[controlPkg::dpJump]     = 1'b1;
                    dpWord[controlPkg::dpLink]     = 1'b1;
                    dpWord[controlPkg::dpRegWrite] = 1'b1;
                end
                controlPkg::opBeq, controlPkg::opBne, controlPkg::opBlez,
                controlPkg::opBgtz: dpWord[controlPkg::dpBranchOrJr] = 1'b1;
                controlPkg::opAddi, controlPkg::opAddiu, controlPkg::opSlti,
                controlPkg::opSltiu, controlPkg::opAndi, controlPkg::opOri,
                controlPkg::opXori, controlPkg::opLui: begin
                    dpWord[controlPkg::dpAluSrcImm] = 1'b1;
                    dpWord[controlPkg::dpRegWrite]  = 1'b1;
                end
                controlPkg::opLb, controlPkg::opLbu, controlPkg::opLh,
                controlPkg::opLhu, controlPkg::opLw: begin
                    dpWord[controlPkg::dpAluSrcImm] = 1'b1;
                    dpWord[controlPkg::dpMemRead]   = 1'b1;
                    dpWord[controlPkg::dpMemToReg]  = 1'b1;
                    dpWord[controlPkg::dpRegWrite]  = 1'b1;
                    dpWord[controlPkg::dpMemByte]   = (opCode == controlPkg::opLb) ||
                                                      (opCode == controlPkg::opLbu);
                    dpWord[controlPkg::dpMemHalf]   = (opCode == controlPkg::opLh) ||
                                                      (opCode == controlPkg::opLhu);
                    // Only the signed narrow loads extend
                    dpWord[controlPkg::dpMemSignExtend] = (opCode == controlPkg::opLb) ||
                                                          (opCode == controlPkg::opLh);
                end
                controlPkg::opSb, controlPkg::opSh, controlPkg::opSw: begin
                    dpWord[controlPkg::dpAluSrcImm] = 1'b1;
                    dpWord[controlPkg::dpMemWrite]  = 1'b1;
                    dpWord[controlPkg::dpMemByte]   = (opCode == controlPkg::opSb);
                    dpWord[controlPkg::dpMemHalf]   = (opCode == controlPkg::opSh);
                end
                default: dpWord = '0;
            endcase
        end
    end

    // Zero extension for andi, ori, xori and lui
    assign signExtend = (opCode[5:2] != 4'b0011);

    assign excSys = (opCode == controlPkg::opTypeR) && (funct == controlPkg::functSyscall);
    assign excBp  = (opCode == controlPkg::opTypeR) && (funct == controlPkg::functBreak);

endmodule

// ==== aluOpDecoder.sv ====
`timescale 1ns/1ps

module aluOpDecoder (
    input  controlPkg::instrWord               instr,
    input  logic                               stall,
    output logic [controlPkg::aluOpWidth-1:0] aluOp
);

    always_comb begin
        // Addu is harmless for anything that does not use the ALU result
        aluOp = controlPkg::aluAddu;
        if (!stall) begin
            case (instr.rType.opCode)
                controlPkg::opTypeR: begin
                    case (instr.rType.funct)
                        controlPkg::functAdd:  aluOp = controlPkg::aluAdd;
                        controlPkg::functAddu: aluOp = controlPkg::aluAddu;
                        controlPkg::functSub:  aluOp = controlPkg::aluSub;
                        controlPkg::functSubu: aluOp = controlPkg::aluSubu;
                        controlPkg::functAnd:  aluOp = controlPkg::aluAnd;
                        controlPkg::functOr:   aluOp = controlPkg::aluOr;
                        controlPkg::functXor:  aluOp = controlPkg::aluXor;
                        controlPkg::functNor:  aluOp = controlPkg::aluNor;
                        controlPkg::functSlt:  aluOp = controlPkg::aluSlt;
                        controlPkg::functSltu: aluOp = controlPkg::aluSltu;
                        controlPkg::functSll:  aluOp = controlPkg::aluSll;
                        controlPkg::functSrl:  aluOp = controlPkg::aluSrl;
                        controlPkg::functSra:  aluOp = controlPkg::aluSra;
                        controlPkg::functSllv: aluOp = controlPkg::aluSllv;
                        controlPkg::functSrlv: aluOp = controlPkg::aluSrlv;
                        controlPkg::functSrav: aluOp = controlPkg::aluSrav;
                        default:               aluOp = controlPkg::aluAddu;
                    endcase
                end
                controlPkg::opAddi:  aluOp = controlPkg::aluAdd;
                controlPkg::opAddiu: aluOp = controlPkg::aluAddu;
                controlPkg::opAndi:  aluOp = controlPkg::aluAnd;
                controlPkg::opOri:   aluOp = controlPkg::aluOr;
                controlPkg::opXori:  aluOp = controlPkg::aluXor;
                controlPkg::opSlti:  aluOp = controlPkg::aluSlt;
                controlPkg::opSltiu: aluOp = controlPkg::aluSltu;
                // Immediate shifted into the upper half
                controlPkg::opLui:   aluOp = controlPkg::aluSllc;
                default:             aluOp = controlPkg::aluAddu;
            endcase
        end
    end

endmodule

// ==== branchResolver.sv ====
`timescale 1ns/1ps

module branchResolver (
    input  logic [controlPkg::dpWidth-1:0] dpWord,
    input  logic [5:0]                     opCode,
    input  logic                           rtLsb,
    input  logic                           cmpEq,
    input  logic                           cmpGz,
    input  logic                           cmpGez,
    input  logic                           cmpLz,
    input  logic                           cmpLez,
    output logic [1:0]                     pcSrc,
    output logic                           nextIsDelay
);

    logic jump;
    logic branchOrJr;
    logic taken;

    assign jump       = dpWord[controlPkg::dpJump];
    assign branchOrJr = dpWord[controlPkg::dpBranchOrJr];

    // Opcode low bits pick one compare
    // Rt bit 0 splits the regimm group
    assign taken = ( opCode[2] & ~opCode[1] & ~opCode[0] &  cmpEq)
                 | ( opCode[2] & ~opCode[1] &  opCode[0] & ~cmpEq)
                 | ( opCode[2] &  opCode[1] &  opCode[0] &  cmpGz)
                 | ( opCode[2] &  opCode[1] & ~opCode[0] &  cmpLez)
                 | (~opCode[2] &  rtLsb & cmpGez)
                 | (~opCode[2] & ~rtLsb & cmpLz);

    always_comb begin
        case ({jump, branchOrJr})
            2'b10:   pcSrc = controlPkg::pcJumpImm;
            2'b11:   pcSrc = controlPkg::pcJumpReg;
            2'b01:   pcSrc = taken ? controlPkg::pcBranch : controlPkg::pcSeq;
            default: pcSrc = controlPkg::pcSeq;
        endcase
    end

    // Every jump and branch has a delay slot
    assign nextIsDelay = jump | branchOrJr;

endmodule

// ==== controlUnit.sv ====
`timescale 1ns/1ps

module controlUnit (
    input  controlPkg::instrWord               instr,
    input  logic                               stall,
    input  logic                               cmpEq,
    input  logic                               cmpGz,
    input  logic                               cmpGez,
    input  logic                               cmpLz,
    input  logic                               cmpLez,
    output logic [1:0]                         pcSrc,
    output logic                               link,
    output logic                               signExtend,
    output logic                               movn,
    output logic                               movz,
    output logic                               excSys,
    output logic                               excBp,
    output logic                               nextIsDelay,
    output logic                               regDst,
    output logic                               aluSrcImm,
    output logic [controlPkg::aluOpWidth-1:0] aluOp,
    output logic                               memWrite,
    output logic                               memRead,
    output logic                               memByte,
    output logic                               memHalf,
    output logic                               memSignExtend,
    output logic                               regWrite,
    output logic                               memToReg
);

    logic [controlPkg::dpWidth-1:0] dpWord;

    mainDecoder mainDec (
        .instr      (instr),
        .stall      (stall),
        .dpWord     (dpWord),
        .signExtend (signExtend),
        .excSys     (excSys),
        .excBp      (excBp)
    );

    aluOpDecoder aluDec (
        .instr (instr),
        .stall (stall),
        .aluOp (aluOp)
    );

    branchResolver branchRes (
        .dpWord      (dpWord),
        .opCode      (instr.iType.opCode),
        .rtLsb       (instr.iType.rt[0]),
        .cmpEq       (cmpEq),
        .cmpGz       (cmpGz),
        .cmpGez      (cmpGez),
        .cmpLz       (cmpLz),
        .cmpLez      (cmpLez),
        .pcSrc       (pcSrc),
        .nextIsDelay (nextIsDelay)
    );

    assign link          = dpWord[controlPkg::dpLink];
    assign regDst        = dpWord[controlPkg::dpRegDst];
    assign aluSrcImm     = dpWord[controlPkg::dpAluSrcImm];
    assign memWrite      = dpWord[controlPkg::dpMemWrite];
    assign memRead       = dpWord[controlPkg::dpMemRead];
    assign memByte       = dpWord[controlPkg::dpMemByte];
    assign memHalf       = dpWord[controlPkg::dpMemHalf];
    assign memSignExtend = dpWord[controlPkg::dpMemSignExtend];
    assign regWrite      = dpWord[controlPkg::dpRegWrite];
    assign memToReg      = dpWord[controlPkg::dpMemToReg];

    // Funct bit 0 splits movn from movz
    assign movn = dpWord[controlPkg::dpMovc] &  instr.rType.funct[0];
    assign movz = dpWord[controlPkg::dpMovc] & ~instr.rType.funct[0];

endmodule

// ==== controlRef.svh ====
`ifndef CONTROL_REF_SVH
`define CONTROL_REF_SVH

// Expected value of every controlUnit output
typedef struct packed {
    logic [1:0]                         pcSrc;
    logic                               link;
    logic                               signExtend;
    logic                               movn;
    logic                               movz;
    logic                               excSys;
    logic                               excBp;
    logic                               nextIsDelay;
    logic                               regDst;
    logic                               aluSrcImm;
    logic [controlPkg::aluOpWidth-1:0] aluOp;
    logic                               memWrite;
    logic                               memRead;
    logic                               memByte;
    logic                               memHalf;
    logic                               memSignExtend;
    logic                               regWrite;
    logic                               memToReg;
} ctrlExpect;

// flags is {cmpEq, cmpGz, cmpGez, cmpLz, cmpLez}
function automatic ctrlExpect refControl(controlPkg::instrWord w, logic stallIn,
                                         logic [4:0] flags);
    ctrlExpect e;
    logic [5:0] op;
    logic [5:0] fn;
    logic [4:0] rt;
    logic isR, rAlu, isMov, isJr, isJalr, isJ, isJal;
    logic isRegimm, isBr, iAlu, isLoad, isStore, taken;
    op = w.rType.opCode;
    fn = w.rType.funct;
    rt = w.iType.rt;
    e = '0;
    e.aluOp = controlPkg::aluAddu;
    // Side decodes follow the instruction even under stall
    e.signExtend = !(op == controlPkg::opAndi || op == controlPkg::opOri ||
                     op == controlPkg::opXori || op == controlPkg::opLui);
    e.excSys = (op == controlPkg::opTypeR) && (fn == controlPkg::functSyscall);
    e.excBp  = (op == controlPkg::opTypeR) && (fn == controlPkg::functBreak);
    if (stallIn)
        return e;
    isR = (op == controlPkg::opTypeR);
    rAlu = 1'b0;
    if (isR) begin
        rAlu = 1'b1;
        case (fn)
            controlPkg::functAdd:  e.aluOp = controlPkg::aluAdd;
            controlPkg::functAddu: e.aluOp = controlPkg::aluAddu;
            controlPkg::functSub:  e.aluOp = controlPkg::aluSub;
            controlPkg::functSubu: e.aluOp = controlPkg::aluSubu;
            controlPkg::functAnd:  e.aluOp = controlPkg::aluAnd;
            controlPkg::functOr:   e.aluOp = controlPkg::aluOr;
            controlPkg::functXor:  e.aluOp = controlPkg::aluXor;
            controlPkg::functNor:  e.aluOp = controlPkg::aluNor;
            controlPkg::functSlt:  e.aluOp = controlPkg::aluSlt;
            controlPkg::functSltu: e.aluOp = controlPkg::aluSltu;
            controlPkg::functSll:  e.aluOp = controlPkg::aluSll;
            controlPkg::functSrl:  e.aluOp = controlPkg::aluSrl;
            controlPkg::functSra:  e.aluOp = controlPkg::aluSra;
            controlPkg::functSllv: e.aluOp = controlPkg::aluSllv;
            controlPkg::functSrlv: e.aluOp = controlPkg::aluSrlv;
            controlPkg::functSrav: e.aluOp = controlPkg::aluSrav;
            default:               rAlu = 1'b0;
        endcase
    end
    iAlu = 1'b1;
    case (op)
        controlPkg::opAddi:  e.aluOp = controlPkg::aluAdd;
        controlPkg::opAddiu: e.aluOp = controlPkg::aluAddu;
        controlPkg::opAndi:  e.aluOp = controlPkg::aluAnd;
        controlPkg::opOri:   e.aluOp = controlPkg::aluOr;
        controlPkg::opXori:  e.aluOp = controlPkg::aluXor;
        controlPkg::opSlti:  e.aluOp = controlPkg::aluSlt;
        controlPkg::opSltiu: e.aluOp = controlPkg::aluSltu;
        controlPkg::opLui:   e.aluOp = controlPkg::aluSllc;
        default:             iAlu = 1'b0;
    endcase
    isMov = isR && (fn == controlPkg::functMovn || fn == controlPkg::functMovz);
    isJr = isR && (fn == controlPkg::functJr);
    isJalr = isR && (fn == controlPkg::functJalr);
    isJ = (op == controlPkg::opJ);
    isJal = (op == controlPkg::opJal);
    isRegimm = (op == controlPkg::opTypeBi) &&
               (rt == controlPkg::rtBltz || rt == controlPkg::rtBgez ||
                rt == controlPkg::rtBltzal || rt == controlPkg::rtBgezal);
    isBr = isRegimm || op == controlPkg::opBeq || op == controlPkg::opBne ||
           op == controlPkg::opBlez || op == controlPkg::opBgtz;
    isLoad = op == controlPkg::opLb || op == controlPkg::opLbu || op == controlPkg::opLh ||
             op == controlPkg::opLhu || op == controlPkg::opLw;
    isStore = op == controlPkg::opSb || op == controlPkg::opSh || op == controlPkg::opSw;
    e.regDst = rAlu || isMov || isJalr;
    e.link = isJal || isJalr || (isRegimm && rt[4]);
    e.regWrite = e.regDst || e.link || iAlu || isLoad;
    e.aluSrcImm = iAlu || isLoad || isStore;
    e.memRead = isLoad;
    e.memToReg = isLoad;
    e.memWrite = isStore;
    e.memByte = op == controlPkg::opLb || op == controlPkg::opLbu || op == controlPkg::opSb;
    e.memHalf = op == controlPkg::opLh || op == controlPkg::opLhu || op == controlPkg::opSh;
    e.memSignExtend = op == controlPkg::opLb || op == controlPkg::opLh;
    e.movn = isMov && fn == controlPkg::functMovn;
    e.movz = isMov && fn == controlPkg::functMovz;
    e.nextIsDelay = isJ || isJal || isJr || isJalr || isBr;
    case (op)
        controlPkg::opBeq:  taken = flags[4];
        controlPkg::opBne:  taken = !flags[4];
        controlPkg::opBgtz: taken = flags[3];
        controlPkg::opBlez: taken = flags[0];
        // Rt bit 0 picks the bgez family over the bltz family
        default:            taken = rt[0] ? flags[2] : flags[1];
    endcase
    if (isJ || isJal)
        e.pcSrc = controlPkg::pcJumpImm;
    else if (isJr || isJalr)
        e.pcSrc = controlPkg::pcJumpReg;
    else if (isBr && taken)
        e.pcSrc = controlPkg::pcBranch;
    return e;
endfunction

task automatic checkBit(string name, logic got, logic exp);
    if (got !== exp) begin
        $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
        failRun();
    end
endtask

task automatic checkAluOp(string name, logic [controlPkg::aluOpWidth-1:0] got,
                          logic [controlPkg::aluOpWidth-1:0] exp);
    if (got !== exp) begin
        $display("[ERROR] %0t %s got %0d expected %0d", $time, name, got, exp);
        failRun();
    end
endtask

task automatic checkPcSrc(string name, logic [1:0] got, logic [1:0] exp);
    if (got !== exp) begin
        $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
        failRun();
    end
endtask

`endif

// ==== tbControlUnit.sv ====
`timescale 1ns/1ps

module tbControlUnit;

    localparam int clkPeriod     = 4;
    localparam int resetCycles   = 5;
    localparam int keptReps      = 4;
    localparam int stallVectors  = 100;
    localparam int droppedReps   = 4;
    localparam int randomVectors = 2000;
    localparam int totalVectors  = 48 * keptReps + 8 * 32 + 4 * 4 + stallVectors
                                 + 10 * droppedReps + randomVectors;
    localparam int timeoutNs     = (totalVectors + resetCycles) * clkPeriod * 2;

    logic clk;
    logic reset;
    controlPkg::instrWord instr;
    logic stall, cmpEq, cmpGz, cmpGez, cmpLz, cmpLez;
    logic [1:0] pcSrc;
    logic link, signExtend, movn, movz, excSys, excBp, nextIsDelay, regDst, aluSrcImm;
    logic [controlPkg::aluOpWidth-1:0] aluOp;
    logic memWrite, memRead, memByte, memHalf, memSignExtend, regWrite, memToReg;

    logic checkEn;
    int applied;
    int checksDone;
    logic [31:0] rngState;

    // Kept instructions as 22 R-type functs, 22 primary opcodes and 4 regimm codes
    logic [5:0] keptFuncts [0:21] = '{
        controlPkg::functAdd, controlPkg::functAddu, controlPkg::functSub,
        controlPkg::functSubu, controlPkg::functAnd, controlPkg::functOr,
        controlPkg::functXor, controlPkg::functNor, controlPkg::functSlt,
        controlPkg::functSltu, controlPkg::functSll, controlPkg::functSrl,
        controlPkg::functSra, controlPkg::functSllv, controlPkg::functSrlv,
        controlPkg::functSrav, controlPkg::functJr, controlPkg::functJalr,
        controlPkg::functMovn, controlPkg::functMovz, controlPkg::functSyscall,
        controlPkg::functBreak};
    logic [5:0] keptOps [0:21] = '{
        controlPkg::opJ, controlPkg::opJal, controlPkg::opBeq, controlPkg::opBne,
        controlPkg::opBlez, controlPkg::opBgtz, controlPkg::opAddi, controlPkg::opAddiu,
        controlPkg::opSlti, controlPkg::opSltiu, controlPkg::opAndi, controlPkg::opOri,
        controlPkg::opXori, controlPkg::opLui, controlPkg::opLb, controlPkg::opLh,
        controlPkg::opLw, controlPkg::opLbu, controlPkg::opLhu, controlPkg::opSb,
        controlPkg::opSh, controlPkg::opSw};
    logic [4:0] keptRts [0:3] = '{controlPkg::rtBltz, controlPkg::rtBgez,
                                  controlPkg::rtBltzal, controlPkg::rtBgezal};
    int branchIdx [0:7] = '{24, 25, 26, 27, 44, 45, 46, 47};
    int jumpIdx [0:3] = '{22, 23, 16, 17};
    // mult, tge, teq, mfhi, then cop0, cop1, ll, lwl, sc, swl
    logic [5:0] droppedFuncts [0:3] = '{6'b011000, 6'b110000, 6'b110100, 6'b010000};
    logic [5:0] droppedOps [0:5] = '{6'b010000, 6'b010001, 6'b110000, 6'b100010,
                                     6'b111000, 6'b101010};

    controlUnit dut0 (.*);

    task automatic failRun();
        $display("=== FAIL ===");
        $fatal(1, "stopped at first failure");
    endtask

    `include "controlRef.svh"

    function automatic logic [31:0] nextRandom();
        rngState ^= rngState << 13;
        rngState ^= rngState >> 17;
        rngState ^= rngState << 5;
        return rngState;
    endfunction

    function automatic logic [4:0] randomFlags();
        logic [31:0] r;
        r = nextRandom();
        return r[4:0];
    endfunction

    function automatic controlPkg::instrWord keptWord(int idx);
        controlPkg::instrWord w;
        w = nextRandom();
        if (idx < 22) begin
            w.rType.opCode = controlPkg::opTypeR;
            w.rType.funct = keptFuncts[idx];
        end else if (idx < 44) begin
            w.iType.opCode = keptOps[idx - 22];
        end else begin
            w.iType.opCode = controlPkg::opTypeBi;
            w.iType.rt = keptRts[idx - 44];
        end
        return w;
    endfunction

    function automatic controlPkg::instrWord droppedWord(int k);
        controlPkg::instrWord w;
        w = nextRandom();
        if (k < 4) begin
            w.rType.opCode = controlPkg::opTypeR;
            w.rType.funct = droppedFuncts[k];
        end else begin
            w.iType.opCode = droppedOps[k - 4];
        end
        return w;
    endfunction

    task automatic applyVector(controlPkg::instrWord w, logic s, logic [4:0] flags);
        @(posedge clk);
        instr <= w;
        stall <= s;
        {cmpEq, cmpGz, cmpGez, cmpLz, cmpLez} <= flags;
        checkEn <= 1'b1;
        applied++;
    endtask

    task automatic compareAll(ctrlExpect e);
        checkPcSrc("pcSrc", pcSrc, e.pcSrc);
        checkBit("link", link, e.link);
        checkBit("signExtend", signExtend, e.signExtend);
        checkBit("movn", movn, e.movn);
        checkBit("movz", movz, e.movz);
        checkBit("excSys", excSys, e.excSys);
        checkBit("excBp", excBp, e.excBp);
        checkBit("nextIsDelay", nextIsDelay, e.nextIsDelay);
        checkBit("regDst", regDst, e.regDst);
        checkBit("aluSrcImm", aluSrcImm, e.aluSrcImm);
        checkAluOp("aluOp", aluOp, e.aluOp);
        checkBit("memWrite", memWrite, e.memWrite);
        checkBit("memRead", memRead, e.memRead);
        checkBit("memByte", memByte, e.memByte);
        checkBit("memHalf", memHalf, e.memHalf);
        checkBit("memSignExtend", memSignExtend, e.memSignExtend);
        checkBit("regWrite", regWrite, e.regWrite);
        checkBit("memToReg", memToReg, e.memToReg);
    endtask

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    // Inputs seen here are the ones driven one period earlier
    always @(posedge clk) begin
        if (checkEn && !reset) begin
            compareAll(refControl(instr, stall, {cmpEq, cmpGz, cmpGez, cmpLz, cmpLez}));
            checksDone++;
        end
    end

    initial begin
        #(timeoutNs);
        $display("Timeout: the run did not finish within %0d ns", timeoutNs);
        failRun();
    end

    initial begin
        logic [31:0] s;
        rngState = 32'd56104;
        instr = '0;
        stall = 1'b0;
        {cmpEq, cmpGz, cmpGez, cmpLz, cmpLez} = 5'b0;
        checkEn = 1'b0;
        applied = 0;
        checksDone = 0;
        reset = 1'b1;
        repeat (resetCycles) @(posedge clk);
        reset <= 1'b0;
        for (int r = 0; r < keptReps; r++)
            for (int i = 0; i < 48; i++)
                applyVector(keptWord(i), 1'b0, randomFlags());
        // Each branch against every compare flag combination
        for (int b = 0; b < 8; b++)
            for (int f = 0; f < 32; f++)
                applyVector(keptWord(branchIdx[b]), 1'b0, f[4:0]);
        for (int r = 0; r < 4; r++)
            for (int j = 0; j < 4; j++)
                applyVector(keptWord(jumpIdx[j]), 1'b0, randomFlags());
        for (int i = 0; i < stallVectors; i++) begin
            s = nextRandom();
            applyVector(keptWord(s % 48), 1'b1, randomFlags());
        end
        for (int r = 0; r < droppedReps; r++)
            for (int k = 0; k < 10; k++)
                applyVector(droppedWord(k), 1'b0, randomFlags());
        for (int i = 0; i < randomVectors; i++) begin
            s = nextRandom();
            applyVector(nextRandom(), s[0], s[5:1]);
        end
        @(posedge clk);
        @(negedge clk);
        if (checksDone == applied) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            $display("Only %0d of %0d vectors were checked", checksDone, applied);
            failRun();
        end
    end

endmodule

// ==== files.f ====
+incdir+.
controlPkg.sv
mainDecoder.sv
aluOpDecoder.sv
branchResolver.sv
controlUnit.sv
tbControlUnit.sv

// ==== Bender.yml ====
package:
  name: control_unit

sources:
  - controlPkg.sv
  - mainDecoder.sv
  - aluOpDecoder.sv
  - branchResolver.sv
  - controlUnit.sv
  - target: test
    include_dirs:
      - .
    files:
      - tbControlUnit.sv
